// ==== src/ssm_params.svh ====
`ifndef SSM_PARAMS_SVH
`define SSM_PARAMS_SVH

// ======================================================================
// fixed point format
// ======================================================================

// word width, signed q8.8
`define SSM_DW 16
// fraction bits
`define SSM_FRAC 8

// ======================================================================
// tile geometry
// ======================================================================

// state lanes carried by one tile
`define SSM_N_TILE 4
// tiles summed into one output channel
`define SSM_TILES_PER_GROUP 2
// groups sharing one set of head scalars
`define SSM_GROUPS_PER_HEAD 2

`endif

// ==== src/ssm_pkg.sv ====
`include "ssm_params.svh"

package ssm_pkg;

    // one q8.8 word
    typedef logic signed [`SSM_DW-1:0] data_t;

    // lane vector of a tile, lane 0 in the low word
    typedef data_t [`SSM_N_TILE-1:0] tile_vec_t;

    // operation code of the shared nonlinear unit
    typedef enum logic {
        NL_SOFTPLUS = 1'b0,
        NL_EXP      = 1'b1
    } nl_mode_e;

    // head scalar producer FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2,
        ST_DONE = 2'd3
    } stage_state_e;

    // tile sequencer FSM
    typedef enum logic [1:0] {
        SC_NEED_COEF = 2'd0,
        SC_WAIT_COEF = 2'd1,
        SC_STREAM    = 2'd2,
        SC_OUT_HOLD  = 2'd3
    } scan_state_e;

endpackage

// ==== src/ssm_ifs.sv ====
`timescale 1ns/100ps

// request/response channel toward the nonlinear unit
// one outstanding request at most, response is a single pulse
interface nonlin_req_if
    import ssm_pkg::*;
();
    logic     req_valid;
    logic     req_ready;
    nl_mode_e mode;
    data_t    operand;
    logic     rsp_valid;
    data_t    result;

    modport requester (
        output req_valid, mode, operand,
        input  req_ready, rsp_valid, result
    );

    modport server (
        input  req_valid, mode, operand,
        output req_ready, rsp_valid, result
    );
endinterface

// head scalars handed to the scan datapath
// each valid drops on coef_req, rises with the new value
interface head_coef_if
    import ssm_pkg::*;
();
    logic  coef_req;
    logic  delta_sp_valid;
    data_t delta_sp;
    logic  dA_valid;
    data_t dA;

    modport consumer (
        output coef_req,
        input  delta_sp, dA_valid, dA
    );

    modport delta_producer (
        input  coef_req,
        output delta_sp_valid, delta_sp
    );

    modport decay_producer (
        input  coef_req, delta_sp_valid, delta_sp,
        output dA_valid, dA
    );
endinterface

// ==== src/delta_stage.sv ====
`timescale 1ns/100ps

module delta_stage
    import ssm_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  data_t dt_i,
    input  data_t dt_bias_i,
    head_coef_if.delta_producer coef,
    nonlin_req_if.requester     nl
);
    stage_state_e state_r;
    // delta of the current head
    data_t        delta_r;
    // softplus(delta), held until the next head
    data_t        delta_sp_r;

    // ======================================================================
    // head FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_r <= ST_IDLE;
        end else begin
            case (state_r)
                ST_IDLE, ST_DONE: begin
                    if (coef.coef_req) begin
                        state_r <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (nl.req_ready) begin
                        state_r <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (nl.rsp_valid) begin
                        state_r <= ST_DONE;
                    end
                end
                default: state_r <= ST_IDLE;
            endcase
        end
    end

    // delta = dt + dt_bias, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (coef.coef_req) begin
            delta_r <= dt_i + dt_bias_i;
        end
        if (state_r == ST_WAIT && nl.rsp_valid) begin
            delta_sp_r <= nl.result;
        end
    end

    // softplus request
    assign nl.req_valid = (state_r == ST_REQ);
    assign nl.mode      = NL_SOFTPLUS;
    assign nl.operand   = delta_r;

    assign coef.delta_sp_valid = (state_r == ST_DONE);
    assign coef.delta_sp       = delta_sp_r;

endmodule

// ==== src/decay_stage.sv ====
`timescale 1ns/100ps
`include "ssm_params.svh"

module decay_stage
    import ssm_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  data_t a_i,
    head_coef_if.decay_producer coef,
    nonlin_req_if.requester     nl
);
    stage_state_e                 state_r;
    logic signed [2*`SSM_DW-1:0]  dA_full_w;
    // delta_sp * A before exp
    data_t                        dA_tmp_r;
    data_t                        dA_r;
    logic                         start_w;

    // full product, rescaled on capture
    assign dA_full_w = coef.delta_sp * a_i;

    // new softplus value, ignored on the cycle a new head is requested
    assign start_w = (state_r == ST_IDLE) && coef.delta_sp_valid && !coef.coef_req;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_r <= ST_IDLE;
        end else begin
            case (state_r)
                ST_IDLE: begin
                    if (start_w) begin
                        state_r <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (nl.req_ready) begin
                        state_r <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (nl.rsp_valid) begin
                        state_r <= ST_DONE;
                    end
                end
                // dA stays valid for the whole head
                ST_DONE: begin
                    if (coef.coef_req) begin
                        state_r <= ST_IDLE;
                    end
                end
                default: state_r <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_w) begin
            dA_tmp_r <= data_t'(dA_full_w >>> `SSM_FRAC);
        end
        if (state_r == ST_WAIT && nl.rsp_valid) begin
            dA_r <= nl.result;
        end
    end

    // exp request
    assign nl.req_valid = (state_r == ST_REQ);
    assign nl.mode      = NL_EXP;
    assign nl.operand   = dA_tmp_r;

    assign coef.dA_valid = (state_r == ST_DONE);
    assign coef.dA       = dA_r;

endmodule

// ==== src/nonlin_arbiter.sv ====
`timescale 1ns/100ps

module nonlin_arbiter
    import ssm_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    nonlin_req_if.server    sp_req,
    nonlin_req_if.server    exp_req,
    nonlin_req_if.requester unit
);
    // grant locked from transfer until response
    logic busy_r;
    // owner of the locked grant, 1 = exp side
    logic owner_r;
    // side served last, for round-robin
    logic last_r;
    logic pick_exp_w;

    // both pending, the side not served last wins
    always_comb begin
        if (sp_req.req_valid && exp_req.req_valid) begin
            pick_exp_w = !last_r;
        end else begin
            pick_exp_w = exp_req.req_valid;
        end
    end

    // request toward the unit, mode follows the granted side
    assign unit.req_valid = !busy_r && (sp_req.req_valid || exp_req.req_valid);
    assign unit.mode      = pick_exp_w ? exp_req.mode : sp_req.mode;
    assign unit.operand   = pick_exp_w ? exp_req.operand : sp_req.operand;

    assign sp_req.req_ready  = !busy_r && !pick_exp_w && unit.req_ready;
    assign exp_req.req_ready = !busy_r && pick_exp_w && unit.req_ready;

    // response pulse only to the grant owner
    assign sp_req.rsp_valid  = unit.rsp_valid && !owner_r;
    assign exp_req.rsp_valid = unit.rsp_valid && owner_r;
    assign sp_req.result     = unit.result;
    assign exp_req.result    = unit.result;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy_r  <= 1'b0;
            owner_r <= 1'b0;
            last_r  <= 1'b1;
        end else if (unit.req_valid && unit.req_ready) begin
            busy_r  <= 1'b1;
            owner_r <= pick_exp_w;
        end else if (unit.rsp_valid) begin
            busy_r <= 1'b0;
            last_r <= owner_r;
        end
    end

endmodule

// ==== src/nonlin_unit.sv ====
`timescale 1ns/100ps
`include "ssm_params.svh"

module nonlin_unit
    import ssm_pkg::*;
(
    input  logic clk,
    input  logic rstn,
    nonlin_req_if.server port_s
);
    // 2.0 and 1.0 in q8.8
    localparam data_t SP_KNEE = data_t'(2 <<< `SSM_FRAC);
    localparam data_t ONE     = data_t'(1 <<< `SSM_FRAC);

    logic                         s1_valid_r;
    nl_mode_e                     s1_mode_r;
    data_t                        s1_val_r;
    // result already final after stage 1
    logic                         s1_pass_r;
    data_t                        s1_val_w;
    logic                         s1_pass_w;
    logic signed [2*`SSM_DW-1:0]  sq_w;
    logic                         s2_valid_r;
    data_t                        s2_res_r;
    data_t                        s2_res_w;

    // ======================================================================
    // stage 1 region select and clamp
    // ======================================================================
    always_comb begin
        s1_val_w  = port_s.operand;
        s1_pass_w = 1'b0;
        if (port_s.mode == NL_SOFTPLUS) begin
            if (port_s.operand >= SP_KNEE) begin
                s1_pass_w = 1'b1;
            end else if (port_s.operand <= -SP_KNEE) begin
                s1_val_w  = '0;
                s1_pass_w = 1'b1;
            end else begin
                s1_val_w = port_s.operand + SP_KNEE;
            end
        end else begin
            // exp input kept in [-1.0, 0]
            if (port_s.operand < -ONE) begin
                s1_val_w = -ONE;
            end else if (port_s.operand > data_t'(0)) begin
                s1_val_w = '0;
            end
        end
    end

    // ======================================================================
    // stage 2 quadratic
    // ======================================================================
    assign sq_w = s1_val_r * s1_val_r;

    // softplus (x+2)^2/8, exp 1 + t + t^2/2
    always_comb begin
        if (s1_pass_r) begin
            s2_res_w = s1_val_r;
        end else if (s1_mode_r == NL_SOFTPLUS) begin
            s2_res_w = data_t'(sq_w >>> (`SSM_FRAC + 3));
        end else begin
            s2_res_w = ONE + s1_val_r + data_t'(sq_w >>> (`SSM_FRAC + 1));
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_valid_r <= 1'b0;
            s2_valid_r <= 1'b0;
        end else begin
            s1_valid_r <= port_s.req_valid && port_s.req_ready;
            s2_valid_r <= s1_valid_r;
        end
    end

    always_ff @(posedge clk) begin
        s1_mode_r <= port_s.mode;
        s1_val_r  <= s1_val_w;
        s1_pass_r <= s1_pass_w;
        s2_res_r  <= s2_res_w;
    end

    // one request in flight at a time
    assign port_s.req_ready = !s1_valid_r && !s2_valid_r;
    assign port_s.rsp_valid = s2_valid_r;
    assign port_s.result    = s2_res_r;

endmodule

// ==== src/scan_datapath.sv ====
`timescale 1ns/100ps
`include "ssm_params.svh"

module scan_datapath
    import ssm_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      tile_valid_i,
    output logic      tile_ready_o,
    input  data_t     x_i,
    input  data_t     d_i,
    input  tile_vec_t b_tile_i,
    input  tile_vec_t c_tile_i,
    input  tile_vec_t hprev_tile_i,
    output data_t     y_o,
    output logic      y_valid_o,
    input  logic      y_ready_i,
    head_coef_if.consumer coef
);
    localparam int TW = $clog2(`SSM_TILES_PER_GROUP + 1);
    localparam int GW = $clog2(`SSM_GROUPS_PER_HEAD + 1);
    localparam logic [TW-1:0] TILE_LAST  = TW'(`SSM_TILES_PER_GROUP - 1);
    localparam logic [GW-1:0] GROUP_LAST = GW'(`SSM_GROUPS_PER_HEAD - 1);

    scan_state_e     state_r;
    logic [TW-1:0]   tile_cnt_r;
    logic [GW-1:0]   group_cnt_r;
    logic            coef_req_r;
    logic            take_w;
    data_t           acc_r;
    data_t           acc_base_w;
    data_t           dx_w;
    data_t           hc_sum_w;
    data_t           y_r;
    logic            y_valid_r;

    // q8.8 product, truncated to one word
    function automatic data_t qmul(input data_t a, input data_t b);
        logic signed [2*`SSM_DW-1:0] full;
        full = a * b;
        return data_t'(full >>> `SSM_FRAC);
    endfunction

    assign tile_ready_o = (state_r == SC_STREAM);
    assign take_w       = tile_valid_i && tile_ready_o;

    // ======================================================================
    // lane update and reduction
    // ======================================================================
    assign dx_w = qmul(coef.delta_sp, x_i);

    always_comb begin
        data_t h_next;
        hc_sum_w = '0;
        for (int n = 0; n < `SSM_N_TILE; n++) begin
            // h_next = dA*hprev + dx*B
            h_next   = qmul(coef.dA, hprev_tile_i[n]) + qmul(dx_w, b_tile_i[n]);
            hc_sum_w = hc_sum_w + qmul(h_next, c_tile_i[n]);
        end
    end

    // first tile of a group starts a fresh sum
    assign acc_base_w = (tile_cnt_r == '0) ? '0 : acc_r;

    // ======================================================================
    // sequencing
    // ======================================================================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_r     <= SC_NEED_COEF;
            tile_cnt_r  <= '0;
            group_cnt_r <= '0;
            coef_req_r  <= 1'b0;
            y_valid_r   <= 1'b0;
        end else begin
            coef_req_r <= 1'b0;
            case (state_r)
                // head start, first tile stays on the inputs
                SC_NEED_COEF: begin
                    if (tile_valid_i) begin
                        coef_req_r <= 1'b1;
                        state_r    <= SC_WAIT_COEF;
                    end
                end
                // dA of the previous head still valid while coef_req is high
                SC_WAIT_COEF: begin
                    if (coef.dA_valid && !coef_req_r) begin
                        state_r <= SC_STREAM;
                    end
                end
                SC_STREAM: begin
                    if (take_w) begin
                        if (tile_cnt_r == TILE_LAST) begin
                            tile_cnt_r <= '0;
                            y_valid_r  <= 1'b1;
                            state_r    <= SC_OUT_HOLD;
                        end else begin
                            tile_cnt_r <= tile_cnt_r + 1'b1;
                        end
                    end
                end
                SC_OUT_HOLD: begin
                    if (y_ready_i) begin
                        y_valid_r <= 1'b0;
                        if (group_cnt_r == GROUP_LAST) begin
                            group_cnt_r <= '0;
                            state_r     <= SC_NEED_COEF;
                        end else begin
                            group_cnt_r <= group_cnt_r + 1'b1;
                            state_r     <= SC_STREAM;
                        end
                    end
                end
                default: state_r <= SC_NEED_COEF;
            endcase
        end
    end

    // y = sum of hC over the group + x*D of the last tile
    always_ff @(posedge clk) begin
        if (take_w) begin
            acc_r <= acc_base_w + hc_sum_w;
            if (tile_cnt_r == TILE_LAST) begin
                y_r <= acc_base_w + hc_sum_w + qmul(x_i, d_i);
            end
        end
    end

    assign coef.coef_req = coef_req_r;
    assign y_o           = y_r;
    assign y_valid_o     = y_valid_r;

endmodule

// ==== src/ssm_block_top.sv ====
`timescale 1ns/100ps

module ssm_block_top
    import ssm_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      tile_valid_i,
    output logic      tile_ready_o,
    input  data_t     dt_i,
    input  data_t     dt_bias_i,
    input  data_t     a_i,
    input  data_t     x_i,
    input  data_t     d_i,
    input  tile_vec_t b_tile_i,
    input  tile_vec_t c_tile_i,
    input  tile_vec_t hprev_tile_i,
    output data_t     y_o,
    output logic      y_valid_o,
    input  logic      y_ready_i
);
    // softplus and exp requesters, arbiter to unit
    nonlin_req_if sp_if ();
    nonlin_req_if exp_if ();
    nonlin_req_if unit_if ();
    head_coef_if  coef_if ();

    // ======================================================================
    // head scalars
    // ======================================================================
    delta_stage delta_stage_inst (
        .clk       (clk),
        .rstn      (rstn),
        .dt_i      (dt_i),
        .dt_bias_i (dt_bias_i),
        .coef      (coef_if),
        .nl        (sp_if)
    );

    decay_stage decay_stage_inst (
        .clk  (clk),
        .rstn (rstn),
        .a_i  (a_i),
        .coef (coef_if),
        .nl   (exp_if)
    );

    // shared nonlinear unit
    nonlin_arbiter nonlin_arbiter_inst (
        .clk     (clk),
        .rstn    (rstn),
        .sp_req  (sp_if),
        .exp_req (exp_if),
        .unit    (unit_if)
    );

    nonlin_unit nonlin_unit_inst (
        .clk    (clk),
        .rstn   (rstn),
        .port_s (unit_if)
    );

    // ======================================================================
    // tile stream
    // ======================================================================
    scan_datapath scan_datapath_inst (
        .clk          (clk),
        .rstn         (rstn),
        .tile_valid_i (tile_valid_i),
        .tile_ready_o (tile_ready_o),
        .x_i          (x_i),
        .d_i          (d_i),
        .b_tile_i     (b_tile_i),
        .c_tile_i     (c_tile_i),
        .hprev_tile_i (hprev_tile_i),
        .y_o          (y_o),
        .y_valid_o    (y_valid_o),
        .y_ready_i    (y_ready_i),
        .coef         (coef_if)
    );

endmodule

// ==== tests/ssm_block_assertions.sv ====
`timescale 1ns/100ps

module ssm_block_assertions
    import ssm_pkg::*;
(
    input logic  clk,
    input logic  rstn,
    input logic  tile_valid_i,
    input logic  tile_ready_i,
    input data_t y_i,
    input logic  y_valid_i,
    input logic  y_ready_i
);
    // failures seen so far, read by the testbench
    int fail_count = 0;

    // held output while the sink stalls
    a_stall_hold : assert property (@(posedge clk) disable iff (!rstn)
        y_valid_i && !y_ready_i |=> y_valid_i && $stable(y_i))
    else begin
        $error("y changed or dropped while stalled");
        fail_count++;
    end

    // valids quiet in reset
    a_reset_quiet : assert property (@(posedge clk)
        !rstn |-> !y_valid_i && !tile_ready_i)
    else begin
        $error("valid output high during reset");
        fail_count++;
    end

    // stalled output blocks the tile stream
    a_no_take_stalled : assert property (@(posedge clk) disable iff (!rstn)
        y_valid_i && !y_ready_i |-> !(tile_valid_i && tile_ready_i))
    else begin
        $error("tile accepted while output stalled");
        fail_count++;
    end

endmodule

bind ssm_block_top ssm_block_assertions ssm_block_assertions_inst (
    .clk          (clk),
    .rstn         (rstn),
    .tile_valid_i (tile_valid_i),
    .tile_ready_i (tile_ready_o),
    .y_i          (y_o),
    .y_valid_i    (y_valid_o),
    .y_ready_i    (y_ready_i)
);

// ==== tests/ssm_block_tb.sv ====
`timescale 1ns/100ps
`include "ssm_params.svh"

module ssm_block_tb
    import ssm_pkg::*;
();
    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 200;
    // head scalar selection
    localparam int MODE_RANDOM    = 0;
    localparam int MODE_VARY      = 1;
    localparam int MODE_SOFTPLUS  = 2;
    localparam int MODE_EXP       = 3;

    logic      clk = 1'b0;
    logic      rstn;
    logic      tile_valid_i;
    logic      tile_ready_o;
    data_t     dt_i;
    data_t     dt_bias_i;
    data_t     a_i;
    data_t     x_i;
    data_t     d_i;
    tile_vec_t b_tile_i;
    tile_vec_t c_tile_i;
    tile_vec_t hprev_tile_i;
    data_t     y_o;
    logic      y_valid_o;
    logic      y_ready_i;

    // expected y per group, oldest first
    data_t exp_q[$];
    // dt in all three softplus regions, edges included
    int    sp_dt_list [6] = '{768, 512, -768, -512, 128, -300};
    // A below the exp clamp, above it, inside, far below
    int    exp_a_list [4] = '{-512, 300, -100, -1024};

    ssm_block_top ssm_block_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic data_t fx_mul(input data_t a, input data_t b);
        int full;
        full = int'(a) * int'(b);
        return data_t'(full >>> `SSM_FRAC);
    endfunction

    function automatic data_t softplus_ref(input data_t x);
        int v;
        v = int'(x);
        if (v >= 512) return x;
        if (v <= -512) return '0;
        return data_t'(((v + 512) * (v + 512)) >>> 11);
    endfunction

    function automatic data_t exp_ref(input data_t x);
        int t;
        t = int'(x);
        // keep t in [-1.0, 0]
        if (t < -256) t = -256;
        if (t > 0) t = 0;
        return data_t'(256 + t + ((t * t) >>> 9));
    endfunction

    // summed hC lanes of one tile
    function automatic data_t tile_hc_sum(input data_t dsp, input data_t da, input data_t x,
                                          input tile_vec_t b, input tile_vec_t c,
                                          input tile_vec_t hp);
        data_t dx;
        data_t h;
        data_t sum;
        dx  = fx_mul(dsp, x);
        sum = '0;
        for (int n = 0; n < `SSM_N_TILE; n++) begin
            h   = fx_mul(da, hp[n]) + fx_mul(dx, b[n]);
            sum = sum + fx_mul(h, c[n]);
        end
        return sum;
    endfunction

    function automatic data_t rand_range(input int lo, input int hi);
        return data_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    // ======================================================================
    // stimulus and collection
    // ======================================================================
    // inputs already on the pins, returns one cycle after the transfer
    task automatic send_tile(input string name);
        int waited;
        waited       = 0;
        tile_valid_i = 1'b1;
        while (!tile_ready_o) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_with_failure($sformatf("%s: tile was not accepted in time", name));
            end
        end
        @(negedge clk);
        tile_valid_i = 1'b0;
    endtask

    task automatic drive_heads(input string name, input int n_heads, input int mode);
        data_t h_dt;
        data_t h_bias;
        data_t h_a;
        data_t delta;
        data_t dsp;
        data_t da;
        data_t acc;
        logic  head_first;
        for (int h = 0; h < n_heads; h++) begin
            case (mode)
                MODE_SOFTPLUS: begin
                    h_dt   = data_t'(sp_dt_list[h]);
                    h_bias = '0;
                    h_a    = data_t'(-256);
                end
                MODE_EXP: begin
                    // delta_sp of 1.5 is 392
                    h_dt   = data_t'(384);
                    h_bias = '0;
                    h_a    = data_t'(exp_a_list[h]);
                end
                default: begin
                    h_dt   = rand_range(-1024, 1023);
                    h_bias = rand_range(-256, 255);
                    h_a    = rand_range(-512, 511);
                end
            endcase
            delta = h_dt + h_bias;
            dsp   = softplus_ref(delta);
            da    = exp_ref(fx_mul(dsp, h_a));
            for (int g = 0; g < `SSM_GROUPS_PER_HEAD; g++) begin
                acc = '0;
                for (int t = 0; t < `SSM_TILES_PER_GROUP; t++) begin
                    head_first = (g == 0) && (t == 0);
                    // later tiles of a head may carry other scalars
                    if (head_first || mode != MODE_VARY) begin
                        dt_i      = h_dt;
                        dt_bias_i = h_bias;
                        a_i       = h_a;
                    end else begin
                        dt_i      = rand_range(-1024, 1023);
                        dt_bias_i = rand_range(-256, 255);
                        a_i       = rand_range(-512, 511);
                    end
                    x_i = rand_range(-256, 255);
                    d_i = rand_range(-256, 255);
                    for (int n = 0; n < `SSM_N_TILE; n++) begin
                        b_tile_i[n]     = rand_range(-256, 255);
                        c_tile_i[n]     = rand_range(-256, 255);
                        hprev_tile_i[n] = rand_range(-256, 255);
                    end
                    acc = acc + tile_hc_sum(dsp, da, x_i, b_tile_i, c_tile_i, hprev_tile_i);
                    if (t == `SSM_TILES_PER_GROUP - 1) begin
                        exp_q.push_back(acc + fx_mul(x_i, d_i));
                    end
                    send_tile(name);
                    // idle gap between tiles
                    repeat ($urandom % 3) @(negedge clk);
                end
            end
        end
    endtask

    task automatic collect_groups(input string name, input int count, input int stall_pct);
        int    got;
        int    idle;
        data_t exp_y;
        got  = 0;
        idle = 0;
        while (got < count) begin
            @(negedge clk);
            y_ready_i = ($urandom % 100) >= stall_pct;
            if (y_valid_o && y_ready_i) begin
                assert (exp_q.size() > 0)
                else stop_with_failure($sformatf("%s: output with no group pending", name));
                exp_y = exp_q.pop_front();
                assert (y_o === exp_y)
                else stop_with_failure($sformatf("FAILED %s group %0d: expected %0d, actual %0d",
                                                 name, got, exp_y, y_o));
                got++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT_CYCLES) begin
                    stop_with_failure($sformatf("%s: group %0d never came out", name, got));
                end
            end
        end
        y_ready_i = 1'b1;
        @(negedge clk);
        assert (!y_valid_o && exp_q.size() == 0)
        else stop_with_failure($sformatf("%s: extra or missing group after the last one", name));
    endtask

    task automatic run_phase(input string name, input int n_heads, input int mode,
                             input int stall_pct);
        fork
            drive_heads(name, n_heads, mode);
            collect_groups(name, n_heads * `SSM_GROUPS_PER_HEAD, stall_pct);
        join
    endtask

    // protocol assertions stop the run at their first failure
    always @(negedge clk) begin
        if (ssm_block_top_inst.ssm_block_assertions_inst.fail_count != 0) begin
            stop_with_failure("a protocol assertion failed");
        end
    end

    initial begin
        void'($urandom(14));
        rstn         = 1'b1;
        tile_valid_i = 1'b0;
        dt_i         = '0;
        dt_bias_i    = '0;
        a_i          = '0;
        x_i          = '0;
        d_i          = '0;
        b_tile_i     = '0;
        c_tile_i     = '0;
        hprev_tile_i = '0;
        y_ready_i    = 1'b1;
        #(CLK_PERIOD / 4) rstn = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        run_phase("random_heads", 6, MODE_RANDOM, 0);
        run_phase("head_latch", 4, MODE_VARY, 0);
        run_phase("softplus_regions", 6, MODE_SOFTPLUS, 0);
        run_phase("exp_clamp", 4, MODE_EXP, 0);
        run_phase("backpressure", 6, MODE_RANDOM, 60);

        repeat (2) @(negedge clk);
        if (ssm_block_top_inst.ssm_block_assertions_inst.fail_count != 0) begin
            stop_with_failure("a protocol assertion failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== ssm_block.f ====
+incdir+src
src/ssm_pkg.sv
src/ssm_ifs.sv
src/delta_stage.sv
src/decay_stage.sv
src/nonlin_arbiter.sv
src/nonlin_unit.sv
src/scan_datapath.sv
src/ssm_block_top.sv
tests/ssm_block_assertions.sv
tests/ssm_block_tb.sv

// ==== Bender.yml ====
package:
  name: ssm_block

sources:
  - include_dirs:
      - src
    files:
      - src/ssm_pkg.sv
      - src/ssm_ifs.sv
      - src/delta_stage.sv
      - src/decay_stage.sv
      - src/nonlin_arbiter.sv
      - src/nonlin_unit.sv
      - src/scan_datapath.sv
      - src/ssm_block_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/ssm_block_assertions.sv
      - tests/ssm_block_tb.sv
